/* core_consts.svh */
`ifndef CORE_CONSTS_SVH
`define CORE_CONSTS_SVH

// Architectural register file
`define GPR_COUNT 16
`define GPR_IDX_SIZE 4
`define GPR_SIZE 32

// Zero-extended immediate carried in bits 11 to 0
`define IMMEDIATE_SIZE 12

// Reorder buffer geometry
// Also the number of credits the instruction source starts with
`define ROB_DEPTH 8
`define ROB_IDX_SIZE 3

`endif

/* core_pkg.sv */
`default_nettype none

package core_pkg;

  // Opcode field, instruction bits 31 to 28
  typedef enum logic [3:0] {
    OP_MOV  = 4'd0,
    OP_ADD  = 4'd1,
    OP_SUB  = 4'd2,
    OP_AND  = 4'd3,
    OP_ORR  = 4'd4,
    OP_ADDS = 4'd5,
    OP_SUBS = 4'd6,
    OP_CSEL = 4'd7
  } opcode_t;

  // ARM style condition flags
  typedef struct packed {
    logic n;
    logic z;
    logic c;
    logic v;
  } nzcv_t;

  // Life of one ROB slot
  typedef enum logic [1:0] {
    ROB_FREE    = 2'd0,
    ROB_WAITING = 2'd1,
    ROB_DONE    = 2'd2
  } rob_state_t;

endpackage

`default_nettype wire

/* instr_decoder.sv */
`default_nettype none
`include "core_consts.svh"

module instr_decoder
  import core_pkg::*;
(
  input  logic                       in_clk,
  input  logic                       in_rst,
  input  logic                       instr_valid,
  input  logic [31:0]                instr_word,
  output logic                       d_done,
  output opcode_t                    d_opcode,
  output logic                       d_set_nzcv,
  output logic                       d_uses_nzcv,
  output logic                       d_use_imm,
  output logic [`IMMEDIATE_SIZE-1:0] d_imm,
  output logic [`GPR_IDX_SIZE-1:0]   d_src1,
  output logic [`GPR_IDX_SIZE-1:0]   d_src2,
  output logic [`GPR_IDX_SIZE-1:0]   d_dst
);

  opcode_t word_opcode;

  assign word_opcode = opcode_t'(instr_word[31:28]);

  // Done strobe trails the accepted word by one edge
  always_ff @(posedge in_clk) begin
    if (in_rst) begin
      d_done <= 1'b0;
    end else begin
      d_done <= instr_valid;
    end
  end

  // Field capture, held until the next accepted word
  always_ff @(posedge in_clk) begin
    if (instr_valid) begin
      d_opcode    <= word_opcode;
      d_dst       <= instr_word[27:24];
      d_src1      <= instr_word[23:20];
      d_src2      <= instr_word[19:16];
      d_use_imm   <= instr_word[15];
      d_imm       <= instr_word[`IMMEDIATE_SIZE-1:0];
      // Only the S forms write flags
      d_set_nzcv  <= (word_opcode == OP_ADDS) || (word_opcode == OP_SUBS);
      // CSEL is the only flag reader
      d_uses_nzcv <= (word_opcode == OP_CSEL);
    end
  end

endmodule

`default_nettype wire

/* reg_module.sv */
`default_nettype none
`include "core_consts.svh"

module reg_module
  import core_pkg::*;
(
  input  logic                       in_clk,
  input  logic                       in_rst,
  // Decode fields
  input  logic                       d_done,
  input  opcode_t                    d_opcode,
  input  logic                       d_set_nzcv,
  input  logic                       d_uses_nzcv,
  input  logic                       d_use_imm,
  input  logic [`IMMEDIATE_SIZE-1:0] d_imm,
  input  logic [`GPR_IDX_SIZE-1:0]   d_src1,
  input  logic [`GPR_IDX_SIZE-1:0]   d_src2,
  input  logic [`GPR_IDX_SIZE-1:0]   d_dst,
  // ROB tail and commit group
  input  logic [`ROB_IDX_SIZE-1:0]   next_rob_index,
  input  logic                       commit_valid,
  input  logic [`GPR_IDX_SIZE-1:0]   commit_reg,
  input  logic [`GPR_SIZE-1:0]       commit_value,
  input  logic                       commit_set_nzcv,
  input  nzcv_t                      commit_nzcv,
  input  logic [`ROB_IDX_SIZE-1:0]   commit_rob_index,
  // Dispatch group
  output logic                       dispatch_valid,
  output opcode_t                    disp_opcode,
  output logic [`GPR_IDX_SIZE-1:0]   disp_dst,
  output logic                       disp_set_nzcv,
  output logic                       disp_src1_valid,
  output logic [`GPR_SIZE-1:0]       disp_src1_value,
  output logic [`ROB_IDX_SIZE-1:0]   disp_src1_rob_index,
  output logic                       disp_src2_valid,
  output logic [`GPR_SIZE-1:0]       disp_src2_value,
  output logic [`ROB_IDX_SIZE-1:0]   disp_src2_rob_index,
  output logic                       disp_nzcv_valid,
  output nzcv_t                      disp_nzcv,
  output logic [`ROB_IDX_SIZE-1:0]   disp_nzcv_rob_index
);

  logic [`GPR_SIZE-1:0]     gpr_value [`GPR_COUNT];
  logic                     gpr_valid [`GPR_COUNT];
  logic [`ROB_IDX_SIZE-1:0] gpr_tag   [`GPR_COUNT];
  nzcv_t                    nzcv_value;
  logic                     nzcv_valid;
  logic [`ROB_IDX_SIZE-1:0] nzcv_tag;
  logic                     commit_hits_reg;
  logic                     commit_hits_nzcv;

  // Writeback lands only while the committing entry is still the youngest producer
  assign commit_hits_reg  = commit_valid && (commit_rob_index == gpr_tag[commit_reg]);
  assign commit_hits_nzcv = commit_valid && commit_set_nzcv && (commit_rob_index == nzcv_tag);

  // Source lookup uses the tags from before this edge's rename
  always_comb begin
    dispatch_valid = d_done;
    disp_opcode    = d_opcode;
    disp_dst       = d_dst;
    disp_set_nzcv  = d_set_nzcv;

    disp_src1_valid     = gpr_valid[d_src1];
    disp_src1_value     = gpr_value[d_src1];
    disp_src1_rob_index = gpr_tag[d_src1];
    // Same cycle commit bypass
    if (commit_hits_reg && (commit_reg == d_src1)) begin
      disp_src1_valid = 1'b1;
      disp_src1_value = commit_value;
    end

    disp_src2_valid     = gpr_valid[d_src2];
    disp_src2_value     = gpr_value[d_src2];
    disp_src2_rob_index = gpr_tag[d_src2];
    if (d_use_imm) begin
      disp_src2_valid = 1'b1;
      disp_src2_value = {{(`GPR_SIZE - `IMMEDIATE_SIZE){1'b0}}, d_imm};
    end else if (commit_hits_reg && (commit_reg == d_src2)) begin
      disp_src2_valid = 1'b1;
      disp_src2_value = commit_value;
    end

    // Flag operand only gates instructions that read it
    disp_nzcv_valid     = nzcv_valid || !d_uses_nzcv;
    disp_nzcv           = nzcv_value;
    disp_nzcv_rob_index = nzcv_tag;
    if (commit_hits_nzcv) begin
      disp_nzcv_valid = 1'b1;
      disp_nzcv       = commit_nzcv;
    end
  end

  always_ff @(posedge in_clk) begin
    if (in_rst) begin
      for (int i = 0; i < `GPR_COUNT; i++) begin
        gpr_value[i] <= '0;
        gpr_valid[i] <= 1'b1;
        gpr_tag[i]   <= '0;
      end
      nzcv_value <= '0;
      nzcv_valid <= 1'b1;
      nzcv_tag   <= '0;
    end else begin
      if (commit_hits_reg) begin
        gpr_value[commit_reg] <= commit_value;
        gpr_valid[commit_reg] <= 1'b1;
      end
      if (commit_hits_nzcv) begin
        nzcv_value <= commit_nzcv;
        nzcv_valid <= 1'b1;
      end
      // Rename comes last so a dispatch to the same register wins
      if (d_done) begin
        gpr_valid[d_dst] <= 1'b0;
        gpr_tag[d_dst]   <= next_rob_index;
        if (d_set_nzcv) begin
          nzcv_valid <= 1'b0;
          nzcv_tag   <= next_rob_index;
        end
      end
    end
  end

endmodule

`default_nettype wire

/* reorder_buffer.sv */
`default_nettype none
`include "core_consts.svh"

module reorder_buffer
  import core_pkg::*;
(
  input  logic                     in_clk,
  input  logic                     in_rst,
  // Dispatch group
  input  logic                     dispatch_valid,
  input  opcode_t                  disp_opcode,
  input  logic [`GPR_IDX_SIZE-1:0] disp_dst,
  input  logic                     disp_set_nzcv,
  input  logic                     disp_src1_valid,
  input  logic [`GPR_SIZE-1:0]     disp_src1_value,
  input  logic [`ROB_IDX_SIZE-1:0] disp_src1_rob_index,
  input  logic                     disp_src2_valid,
  input  logic [`GPR_SIZE-1:0]     disp_src2_value,
  input  logic [`ROB_IDX_SIZE-1:0] disp_src2_rob_index,
  input  logic                     disp_nzcv_valid,
  input  nzcv_t                    disp_nzcv,
  input  logic [`ROB_IDX_SIZE-1:0] disp_nzcv_rob_index,
  // ALU
  input  logic [`GPR_SIZE-1:0]     alu_result,
  input  nzcv_t                    alu_nzcv,
  output opcode_t                  alu_opcode,
  output logic [`GPR_SIZE-1:0]     alu_a,
  output logic [`GPR_SIZE-1:0]     alu_b,
  output nzcv_t                    alu_nzcv_in,
  // Rename tail and commit group
  output logic [`ROB_IDX_SIZE-1:0] next_rob_index,
  output logic                     commit_valid,
  output logic [`GPR_IDX_SIZE-1:0] commit_reg,
  output logic [`GPR_SIZE-1:0]     commit_value,
  output logic                     commit_set_nzcv,
  output nzcv_t                    commit_nzcv,
  output logic [`ROB_IDX_SIZE-1:0] commit_rob_index,
  output logic                     credit_return
);

  // Operand slots 0 and 1 are src1 and src2, slot 2 holds the flags zero-extended
  rob_state_t               state      [`ROB_DEPTH];
  opcode_t                  e_opcode   [`ROB_DEPTH];
  logic [`GPR_IDX_SIZE-1:0] e_dst      [`ROB_DEPTH];
  logic                     e_set_nzcv [`ROB_DEPTH];
  logic                     op_valid   [`ROB_DEPTH][3];
  logic [`GPR_SIZE-1:0]     op_value   [`ROB_DEPTH][3];
  logic [`ROB_IDX_SIZE-1:0] op_tag     [`ROB_DEPTH][3];
  logic [`GPR_SIZE-1:0]     e_result   [`ROB_DEPTH];
  nzcv_t                    e_flags    [`ROB_DEPTH];
  logic [`ROB_IDX_SIZE-1:0] head;
  logic [`ROB_IDX_SIZE-1:0] tail;
  logic [`ROB_IDX_SIZE:0]   occupancy;
  nzcv_t                    arch_flags;
  logic                     issue_valid;
  logic [`ROB_IDX_SIZE-1:0] issue_idx;
  logic [`ROB_IDX_SIZE-1:0] scan_idx;
  logic                     new_valid  [3];
  logic [`GPR_SIZE-1:0]     new_value  [3];
  logic [`ROB_IDX_SIZE-1:0] new_tag    [3];
  logic [`GPR_SIZE-1:0]     alu_flags_word;

  assign alu_flags_word = {{(`GPR_SIZE - 4){1'b0}}, alu_nzcv};

  // Oldest ready entry, scanning forward from the head
  always_comb begin
    issue_valid = 1'b0;
    issue_idx   = head;
    for (int i = 0; i < `ROB_DEPTH; i++) begin
      scan_idx = head + i[`ROB_IDX_SIZE-1:0];
      if (!issue_valid && (state[scan_idx] == ROB_WAITING) && op_valid[scan_idx][0] &&
          op_valid[scan_idx][1] && op_valid[scan_idx][2]) begin
        issue_valid = 1'b1;
        issue_idx   = scan_idx;
      end
    end
  end

  // Late operands pulled from finished entries or from this cycle's ALU result
  always_comb begin
    new_valid[0] = disp_src1_valid;
    new_value[0] = disp_src1_value;
    new_tag[0]   = disp_src1_rob_index;
    new_valid[1] = disp_src2_valid;
    new_value[1] = disp_src2_value;
    new_tag[1]   = disp_src2_rob_index;
    new_valid[2] = disp_nzcv_valid;
    new_value[2] = {{(`GPR_SIZE - 4){1'b0}}, disp_nzcv};
    new_tag[2]   = disp_nzcv_rob_index;
    for (int k = 0; k < 3; k++) begin
      if (!new_valid[k] && (state[new_tag[k]] == ROB_DONE)) begin
        new_valid[k] = 1'b1;
        new_value[k] = (k == 2) ? {{(`GPR_SIZE - 4){1'b0}}, e_flags[new_tag[k]]}
                                : e_result[new_tag[k]];
      end else if (!new_valid[k] && issue_valid && (issue_idx == new_tag[k])) begin
        new_valid[k] = 1'b1;
        new_value[k] = (k == 2) ? alu_flags_word : alu_result;
      end
    end
  end

  assign alu_opcode  = e_opcode[issue_idx];
  assign alu_a       = op_value[issue_idx][0];
  assign alu_b       = op_value[issue_idx][1];
  assign alu_nzcv_in = nzcv_t'(op_value[issue_idx][2][3:0]);

  // Head retires once its result is in
  assign commit_valid     = (occupancy != '0) && (state[head] == ROB_DONE);
  assign commit_reg       = e_dst[head];
  assign commit_value     = e_result[head];
  assign commit_set_nzcv  = e_set_nzcv[head];
  assign commit_nzcv      = e_set_nzcv[head] ? e_flags[head] : arch_flags;
  assign commit_rob_index = head;
  assign credit_return    = commit_valid;
  assign next_rob_index   = tail;

  always_ff @(posedge in_clk) begin
    if (in_rst) begin
      head       <= '0;
      tail       <= '0;
      occupancy  <= '0;
      arch_flags <= '0;
      for (int i = 0; i < `ROB_DEPTH; i++) begin
        state[i] <= ROB_FREE;
      end
    end else begin
      if (issue_valid) begin
        state[issue_idx] <= ROB_DONE;
      end
      if (commit_valid) begin
        state[head] <= ROB_FREE;
        head        <= head + 1'b1;
        // Committed flags in program order
        if (e_set_nzcv[head]) begin
          arch_flags <= e_flags[head];
        end
      end
      if (dispatch_valid) begin
        state[tail] <= ROB_WAITING;
        tail        <= tail + 1'b1;
      end
      occupancy <= occupancy + {{`ROB_IDX_SIZE{1'b0}}, dispatch_valid}
                             - {{`ROB_IDX_SIZE{1'b0}}, commit_valid};
    end
  end

  always_ff @(posedge in_clk) begin
    if (issue_valid) begin
      e_result[issue_idx] <= alu_result;
      e_flags[issue_idx]  <= alu_nzcv;
    end
    // Broadcast the finishing entry to its waiting consumers
    for (int i = 0; i < `ROB_DEPTH; i++) begin
      for (int k = 0; k < 3; k++) begin
        if (issue_valid && (state[i] == ROB_WAITING) && !op_valid[i][k] &&
            (op_tag[i][k] == issue_idx)) begin
          op_valid[i][k] <= 1'b1;
          op_value[i][k] <= (k == 2) ? alu_flags_word : alu_result;
        end
      end
    end
    if (dispatch_valid) begin
      e_opcode[tail]   <= disp_opcode;
      e_dst[tail]      <= disp_dst;
      e_set_nzcv[tail] <= disp_set_nzcv;
      for (int k = 0; k < 3; k++) begin
        op_valid[tail][k] <= new_valid[k];
        op_value[tail][k] <= new_value[k];
        op_tag[tail][k]   <= new_tag[k];
      end
    end
  end

endmodule

`default_nettype wire

/* alu_unit.sv */
`default_nettype none
`include "core_consts.svh"

module alu_unit
  import core_pkg::*;
(
  input  opcode_t              alu_opcode,
  input  logic [`GPR_SIZE-1:0] alu_a,
  input  logic [`GPR_SIZE-1:0] alu_b,
  input  nzcv_t                alu_nzcv_in,
  output logic [`GPR_SIZE-1:0] alu_result,
  output nzcv_t                alu_nzcv
);

  localparam int MSB = `GPR_SIZE - 1;

  logic [`GPR_SIZE:0] sum;
  logic [`GPR_SIZE:0] diff;

  // Extra bit is the carry out
  assign sum  = {1'b0, alu_a} + {1'b0, alu_b};
  // Carry set means no borrow
  assign diff = {1'b0, alu_a} + {1'b0, ~alu_b} + {{`GPR_SIZE{1'b0}}, 1'b1};

  always_comb begin
    alu_nzcv = alu_nzcv_in;
    case (alu_opcode)
      OP_MOV:          alu_result = alu_b;
      OP_ADD, OP_ADDS: alu_result = sum[MSB:0];
      OP_SUB, OP_SUBS: alu_result = diff[MSB:0];
      OP_AND:          alu_result = alu_a & alu_b;
      OP_ORR:          alu_result = alu_a | alu_b;
      // Z set picks src1
      OP_CSEL:         alu_result = alu_nzcv_in.z ? alu_a : alu_b;
      default:         alu_result = '0;
    endcase
    if (alu_opcode == OP_ADDS) begin
      alu_nzcv.n = sum[MSB];
      alu_nzcv.z = (sum[MSB:0] == '0);
      alu_nzcv.c = sum[`GPR_SIZE];
      alu_nzcv.v = (alu_a[MSB] == alu_b[MSB]) && (sum[MSB] != alu_a[MSB]);
    end else if (alu_opcode == OP_SUBS) begin
      alu_nzcv.n = diff[MSB];
      alu_nzcv.z = (diff[MSB:0] == '0);
      alu_nzcv.c = diff[`GPR_SIZE];
      alu_nzcv.v = (alu_a[MSB] != alu_b[MSB]) && (diff[MSB] != alu_a[MSB]);
    end
  end

endmodule

`default_nettype wire

/* rename_core.sv */
`default_nettype none
`include "core_consts.svh"

module rename_core
  import core_pkg::*;
(
  input  logic                     in_clk,
  input  logic                     in_rst,
  input  logic                     instr_valid,
  input  logic [31:0]              instr_word,
  output logic                     credit_return,
  output logic                     commit_valid,
  output logic [`GPR_IDX_SIZE-1:0] commit_reg,
  output logic [`GPR_SIZE-1:0]     commit_value,
  output nzcv_t                    commit_nzcv
);

  // Decode to register status
  logic                       d_done;
  opcode_t                    d_opcode;
  logic                       d_set_nzcv;
  logic                       d_uses_nzcv;
  logic                       d_use_imm;
  logic [`IMMEDIATE_SIZE-1:0] d_imm;
  logic [`GPR_IDX_SIZE-1:0]   d_src1;
  logic [`GPR_IDX_SIZE-1:0]   d_src2;
  logic [`GPR_IDX_SIZE-1:0]   d_dst;
  // Dispatch group
  logic                       dispatch_valid;
  opcode_t                    disp_opcode;
  logic [`GPR_IDX_SIZE-1:0]   disp_dst;
  logic                       disp_set_nzcv;
  logic                       disp_src1_valid;
  logic [`GPR_SIZE-1:0]       disp_src1_value;
  logic [`ROB_IDX_SIZE-1:0]   disp_src1_rob_index;
  logic                       disp_src2_valid;
  logic [`GPR_SIZE-1:0]       disp_src2_value;
  logic [`ROB_IDX_SIZE-1:0]   disp_src2_rob_index;
  logic                       disp_nzcv_valid;
  nzcv_t                      disp_nzcv;
  logic [`ROB_IDX_SIZE-1:0]   disp_nzcv_rob_index;
  // ROB back to register status
  logic [`ROB_IDX_SIZE-1:0]   next_rob_index;
  logic                       commit_set_nzcv;
  logic [`ROB_IDX_SIZE-1:0]   commit_rob_index;
  // Issue path
  opcode_t                    alu_opcode;
  logic [`GPR_SIZE-1:0]       alu_a;
  logic [`GPR_SIZE-1:0]       alu_b;
  nzcv_t                      alu_nzcv_in;
  logic [`GPR_SIZE-1:0]       alu_result;
  nzcv_t                      alu_nzcv;

  // Port names match across blocks
  instr_decoder  u_decoder (.*);
  reg_module     u_regs    (.*);
  reorder_buffer u_rob     (.*);
  alu_unit       u_alu     (.*);

endmodule

`default_nettype wire

/* rename_core_properties.sv */
`default_nettype none
`include "core_consts.svh"

module rename_core_properties (
  input logic                     in_clk,
  input logic                     in_rst,
  input logic                     commit_valid,
  input logic [`ROB_IDX_SIZE-1:0] commit_rob_index,
  input logic [`ROB_IDX_SIZE-1:0] next_rob_index,
  input logic [`ROB_IDX_SIZE:0]   occupancy
);

  // Oldest slot still in flight, counted back from the tail
  logic [`ROB_IDX_SIZE-1:0] oldest_idx;

  assign oldest_idx = next_rob_index - occupancy[`ROB_IDX_SIZE-1:0];

  // Credits bound the number in flight
  occupancy_bound: assert property (@(posedge in_clk) disable iff (in_rst)
    occupancy <= (`ROB_IDX_SIZE + 1)'(`ROB_DEPTH))
    else $error("ROB holds more entries than its depth");

  // Nothing retires while reset is held
  reset_quiet: assert property (@(posedge in_clk)
    (in_rst && $past(in_rst)) |-> !commit_valid)
    else $error("commit seen during reset");

  // Program order, each commit takes the oldest slot so the index steps by one
  commit_order: assert property (@(posedge in_clk) disable iff (in_rst)
    commit_valid |-> (commit_rob_index == oldest_idx))
    else $error("commit index out of program order");

endmodule

bind reorder_buffer rename_core_properties u_props (
  .in_clk           (in_clk),
  .in_rst           (in_rst),
  .commit_valid     (commit_valid),
  .commit_rob_index (commit_rob_index),
  .next_rob_index   (next_rob_index),
  .occupancy        (occupancy)
);

`default_nettype wire

/* tb_rename_core.sv */
`default_nettype none
`include "core_consts.svh"

module tb_rename_core
  import core_pkg::*;
();

  logic                     in_clk;
  logic                     in_rst;
  logic                     instr_valid;
  logic [31:0]              instr_word;
  logic                     credit_return;
  logic                     commit_valid;
  logic [`GPR_IDX_SIZE-1:0] commit_reg;
  logic [`GPR_SIZE-1:0]     commit_value;
  nzcv_t                    commit_nzcv;

  // Architectural model, stepped in program order at send time
  logic [`GPR_SIZE-1:0]     model_regs [`GPR_COUNT];
  nzcv_t                    model_flags;
  // Expected commits, indexed by commit number
  logic [`GPR_IDX_SIZE-1:0] exp_reg_q[$];
  logic [`GPR_SIZE-1:0]     exp_val_q[$];
  nzcv_t                    exp_nzcv_q[$];
  // Words of the test being run
  logic [31:0]              program_q[$];

  string test_name;
  int    sent_count;
  int    commit_count;
  int    credits_returned;
  int    check_errors;
  int    misc_errors;
  int    cycle_count;
  int    test_count;

  rename_core UUT (
    .in_clk        (in_clk),
    .in_rst        (in_rst),
    .instr_valid   (instr_valid),
    .instr_word    (instr_word),
    .credit_return (credit_return),
    .commit_valid  (commit_valid),
    .commit_reg    (commit_reg),
    .commit_value  (commit_value),
    .commit_nzcv   (commit_nzcv)
  );

  always #20 in_clk = ~in_clk;

  function automatic logic [31:0] imm_word(input opcode_t op,
                                           input logic [`GPR_IDX_SIZE-1:0] dst,
                                           input logic [`GPR_IDX_SIZE-1:0] src1,
                                           input logic [`IMMEDIATE_SIZE-1:0] imm);
    return {op, dst, src1, 4'd0, 1'b1, 3'b000, imm};
  endfunction

  function automatic logic [31:0] reg_word(input opcode_t op,
                                           input logic [`GPR_IDX_SIZE-1:0] dst,
                                           input logic [`GPR_IDX_SIZE-1:0] src1,
                                           input logic [`GPR_IDX_SIZE-1:0] src2);
    return {op, dst, src1, src2, 1'b0, 3'b000, 12'h000};
  endfunction

  // Sequential execution of one word, queues its expected commit
  function automatic void reference_exec(input logic [31:0] word);
    opcode_t     op;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] res;
    logic [63:0] wide;
    longint      exact;
    op = opcode_t'(word[31:28]);
    a = model_regs[word[23:20]];
    b = word[15] ? {20'h00000, word[11:0]} : model_regs[word[19:16]];
    res = '0;
    case (op)
      OP_MOV: res = b;
      OP_ADD: res = a + b;
      OP_SUB: res = a - b;
      OP_AND: res = a & b;
      OP_ORR: res = a | b;
      OP_ADDS: begin
        wide = {32'h0, a} + {32'h0, b};
        res = wide[31:0];
        exact = longint'($signed(a)) + longint'($signed(b));
        model_flags.c = wide[32];
        model_flags.v = (exact != longint'($signed(res)));
      end
      OP_SUBS: begin
        res = a - b;
        exact = longint'($signed(a)) - longint'($signed(b));
        // No borrow means carry
        model_flags.c = (a >= b);
        model_flags.v = (exact != longint'($signed(res)));
      end
      OP_CSEL: res = model_flags.z ? a : b;
      default: res = '0;
    endcase
    if ((op == OP_ADDS) || (op == OP_SUBS)) begin
      model_flags.n = res[31];
      model_flags.z = (res == 32'h0);
    end
    model_regs[word[27:24]] = res;
    exp_reg_q.push_back(word[27:24]);
    exp_val_q.push_back(res);
    exp_nzcv_q.push_back(model_flags);
  endfunction

  task automatic check_value(input logic [`GPR_SIZE-1:0] expected,
                             input logic [`GPR_SIZE-1:0] actual);
    if (actual !== expected) begin
      $display("error %s commit %0d value: expected %h, actual %h",
               test_name, commit_count, expected, actual);
      check_errors++;
    end
  endtask

  task automatic check_reg(input logic [`GPR_IDX_SIZE-1:0] expected,
                           input logic [`GPR_IDX_SIZE-1:0] actual);
    if (actual !== expected) begin
      $display("error %s commit %0d register: expected %0d, actual %0d",
               test_name, commit_count, expected, actual);
      check_errors++;
    end
  endtask

  task automatic check_nzcv(input nzcv_t expected, input nzcv_t actual);
    if (actual !== expected) begin
      $display("error %s commit %0d nzcv: expected %b, actual %b",
               test_name, commit_count, expected, actual);
      check_errors++;
    end
  endtask

  // Sampled mid cycle, where commit outputs are settled
  always @(negedge in_clk) begin
    if (in_rst) begin
      commit_count     = 0;
      check_errors     = 0;
      credits_returned = 0;
    end else begin
      // One credit back per commit
      if (credit_return !== commit_valid) begin
        $display("%s: credit return does not follow the commit strobe", test_name);
        check_errors++;
      end
      if (credit_return) begin
        credits_returned++;
      end
      if (commit_valid) begin
        if (commit_count >= exp_val_q.size()) begin
          $display("%s: a commit arrived with no instruction outstanding", test_name);
          check_errors++;
        end else begin
          check_reg(exp_reg_q[commit_count], commit_reg);
          check_value(exp_val_q[commit_count], commit_value);
          check_nzcv(exp_nzcv_q[commit_count], commit_nzcv);
        end
        commit_count++;
      end
    end
  end

  // Watchdog scaled by the instructions sent so far
  always @(posedge in_clk) begin
    if (in_rst) begin
      cycle_count = 0;
    end else begin
      cycle_count++;
      if (cycle_count > 60 * sent_count + 200) begin
        $display("timeout in %s: %0d of %0d instructions committed",
                 test_name, commit_count, sent_count);
        $display("Done: errors found");
        $finish;
      end
    end
  end

  function automatic int credits_left();
    return `ROB_DEPTH - (sent_count - credits_returned);
  endfunction

  task automatic send_word(input logic [31:0] word);
    // Stall while no credit is left
    while (credits_left() <= 0) begin
      instr_valid = 1'b0;
      @(posedge in_clk);
      #2;
    end
    instr_valid = 1'b1;
    instr_word  = word;
    sent_count++;
    reference_exec(word);
    @(posedge in_clk);
    #2;
  endtask

  task automatic run_program(input string name);
    int errors_before;
    int first;
    int wait_cycles;
    test_name = name;
    errors_before = check_errors + misc_errors;
    first = sent_count;
    while (program_q.size() != 0) begin
      send_word(program_q.pop_front());
    end
    instr_valid = 1'b0;
    // Drain, at most a full ROB is still in flight
    wait_cycles = 0;
    while ((commit_count < sent_count) && (wait_cycles < 60 * `ROB_DEPTH)) begin
      @(posedge in_clk);
      #2;
      wait_cycles++;
    end
    if (commit_count != exp_val_q.size()) begin
      $display("%s: %0d instructions sent but %0d commits seen",
               name, exp_val_q.size(), commit_count);
      misc_errors++;
    end
    test_count++;
    $display("test %s: %0d instructions, %0d errors",
             name, sent_count - first, check_errors + misc_errors - errors_before);
  endtask

  initial begin
    logic [31:0] rnd;
    in_clk      = 1'b0;
    in_rst      = 1'b1;
    instr_valid = 1'b0;
    instr_word  = '0;
    sent_count  = 0;
    misc_errors = 0;
    test_count  = 0;
    test_name   = "reset";
    model_flags = '0;
    for (int i = 0; i < `GPR_COUNT; i++) begin
      model_regs[i] = '0;
    end
    void'($urandom(32'h6a0));
    repeat (8) @(posedge in_clk);
    #2;
    in_rst = 1'b0;

    // Independent immediates from a zeroed file
    program_q.push_back(imm_word(OP_MOV, 4'd1, 4'd0, 12'h005));
    program_q.push_back(imm_word(OP_MOV, 4'd2, 4'd0, 12'h123));
    program_q.push_back(imm_word(OP_ADD, 4'd3, 4'd0, 12'h007));
    program_q.push_back(imm_word(OP_ADD, 4'd4, 4'd5, 12'h064));
    run_program("independent_imm");

    // Dependency chain, some sources equal dst
    program_q.push_back(imm_word(OP_MOV, 4'd1, 4'd0, 12'h00a));
    program_q.push_back(reg_word(OP_ADD, 4'd2, 4'd1, 4'd1));
    program_q.push_back(reg_word(OP_SUB, 4'd3, 4'd2, 4'd1));
    program_q.push_back(reg_word(OP_AND, 4'd4, 4'd3, 4'd2));
    program_q.push_back(reg_word(OP_ORR, 4'd4, 4'd4, 4'd1));
    program_q.push_back(imm_word(OP_ADD, 4'd1, 4'd1, 12'h001));
    program_q.push_back(reg_word(OP_SUB, 4'd3, 4'd3, 4'd4));
    run_program("raw_chain");

    // Flag producers then CSEL with Z set and clear
    program_q.push_back(imm_word(OP_MOV, 4'd5, 4'd0, 12'h004));
    program_q.push_back(imm_word(OP_SUBS, 4'd6, 4'd5, 12'h004));
    program_q.push_back(reg_word(OP_CSEL, 4'd7, 4'd5, 4'd1));
    program_q.push_back(imm_word(OP_ADDS, 4'd8, 4'd5, 12'h001));
    program_q.push_back(imm_word(OP_CSEL, 4'd9, 4'd5, 12'h077));
    program_q.push_back(imm_word(OP_SUBS, 4'd10, 4'd0, 12'h001));
    program_q.push_back(reg_word(OP_CSEL, 4'd2, 4'd6, 4'd10));
    program_q.push_back(reg_word(OP_ADDS, 4'd15, 4'd10, 4'd10));
    run_program("nzcv_csel");

    // Longer than the ROB, runs into the credit limit
    for (int i = 0; i < 20; i++) begin
      program_q.push_back(imm_word(OP_ADD, 4'd11, 4'd11, 12'h003));
    end
    run_program("credit_burst");

    // Two writes to r12 before either commits
    program_q.push_back(imm_word(OP_MOV, 4'd12, 4'd0, 12'h001));
    program_q.push_back(imm_word(OP_MOV, 4'd12, 4'd0, 12'h002));
    program_q.push_back(imm_word(OP_ADD, 4'd13, 4'd12, 12'h000));
    program_q.push_back(reg_word(OP_ORR, 4'd14, 4'd12, 4'd13));
    program_q.push_back(imm_word(OP_SUB, 4'd12, 4'd12, 12'h001));
    program_q.push_back(reg_word(OP_ADD, 4'd13, 4'd12, 4'd14));
    run_program("double_write");

    // Random words over all eight opcodes
    for (int i = 0; i < 200; i++) begin
      rnd = $urandom;
      program_q.push_back({1'b0, rnd[2:0], rnd[7:4], rnd[11:8], rnd[15:12],
                           rnd[31], 3'b000, rnd[27:16]});
    end
    run_program("random_200");

    $display("%0d tests, %0d instructions, %0d commits, %0d errors",
             test_count, sent_count, commit_count, check_errors + misc_errors);
    if ((check_errors + misc_errors) == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* build.f */
+incdir+.
core_pkg.sv
instr_decoder.sv
reg_module.sv
reorder_buffer.sv
alu_unit.sv
rename_core.sv
rename_core_properties.sv
tb_rename_core.sv

/* run_sim.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -f build.f --top-module tb_rename_core -Mdir obj_dir
./obj_dir/Vtb_rename_core 2>&1 | tee sim.log
if grep -q "^Done: no errors$" sim.log; then
  echo "simulation passed"
else
  echo "simulation failed"
  exit 1
fi
